/* rtl/bp_cfg.svh */
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Width of fetch and branch addresses
`define BP_ADDR_W 32

// Global history length
`define BP_HIST_W 3

// One 2-bit counter per history pattern
`define BP_PHT_DEPTH (1 << `BP_HIST_W)

// BTB index width and its position in the address
`define BP_BTB_IDX_W 3
`define BP_BTB_IDX_LSB 2

// Direct-mapped BTB entries
`define BP_BTB_DEPTH (1 << `BP_BTB_IDX_W)

`endif

/* rtl/bp_pkg.sv */
`include "bp_cfg.svh"

package bp_pkg;

  // Fetch address presented by the front end
  typedef struct packed {
    logic [`BP_ADDR_W-1:0] pc;
  } bp_lookup_t;

  // Resolved branch from the back end
  typedef struct packed {
    logic                  valid;
    logic [`BP_ADDR_W-1:0] pc;
    logic                  taken;
    logic [`BP_ADDR_W-1:0] target;
  } bp_update_t;

  // Lookup result returned to fetch
  typedef struct packed {
    logic                  taken;
    logic                  hit;
    logic [`BP_ADDR_W-1:0] target;
  } bp_predict_t;

  // Upper bit of the encoding is the direction guess
  typedef enum logic [1:0] {
    strong_nt = 2'b00,
    weak_nt   = 2'b01,
    weak_t    = 2'b10,
    strong_t  = 2'b11
  } ctr_state_t;

  // One saturating step toward the resolved direction
  function automatic ctr_state_t ctr_step(ctr_state_t state, logic taken);
    ctr_state_t next;
    unique case (state)
      strong_nt: next = taken ? weak_nt  : strong_nt;
      weak_nt:   next = taken ? weak_t   : strong_nt;
      weak_t:    next = taken ? strong_t : weak_nt;
      default:   next = taken ? strong_t : weak_t;
    endcase
    return next;
  endfunction

  // Direction guess held by a counter
  function automatic logic ctr_predict(ctr_state_t state);
    return state[1];
  endfunction

  // BTB set selected by an address
  function automatic logic [`BP_BTB_IDX_W-1:0] btb_index(logic [`BP_ADDR_W-1:0] addr);
    return addr[`BP_BTB_IDX_LSB +: `BP_BTB_IDX_W];
  endfunction

endpackage

/* rtl/two_level_predictor.sv */
`timescale 1ns/1ps
`include "bp_cfg.svh"

// Global history selects one of the pattern table counters
module two_level_predictor (
  input  logic clk,
  input  logic rst_n,
  input  logic upd_valid,
  input  logic upd_taken,
  output logic pred_taken
);
  import bp_pkg::*;

  // Global branch history, newest outcome in bit 0
  logic [`BP_HIST_W-1:0] hist_q;
  logic [`BP_HIST_W-1:0] hist_d;

  // Pattern history table
  ctr_state_t pht_q [`BP_PHT_DEPTH];

  // Counter picked by the current history
  ctr_state_t ctr_cur;
  ctr_state_t ctr_nxt;

  // One-hot write enable into the table
  logic [`BP_PHT_DEPTH-1:0] ctr_en;

  // Read side and next values
  always_comb begin
    ctr_cur = pht_q[hist_q];
    ctr_nxt = ctr_step(ctr_cur, upd_taken);
    hist_d  = {hist_q[`BP_HIST_W-2:0], upd_taken};
  end

  // Decode which counter trains on this update
  always_comb begin
    ctr_en         = '0;
    ctr_en[hist_q] = upd_valid;
  end

  // Guess from the selected counter
  assign pred_taken = ctr_predict(ctr_cur);

  // History shifts on every resolved branch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hist_q <= '0;
    end else if (upd_valid) begin
      hist_q <= hist_d;
    end
  end

  // Counters come out of reset strongly not taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
        pht_q[i] <= strong_nt;
      end
    end else begin
      for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
        // Indexed by the old history
        if (ctr_en[i]) begin
          pht_q[i] <= ctr_nxt;
        end
      end
    end
  end

endmodule

/* rtl/target_buffer.sv */
`timescale 1ns/1ps
`include "bp_cfg.svh"

// Direct-mapped branch target buffer with full address tags
module target_buffer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  bp_pkg::bp_update_t    update,
  input  logic [`BP_ADDR_W-1:0] lookup_pc,
  output logic                  hit,
  output logic [`BP_ADDR_W-1:0] target
);
  import bp_pkg::*;

  // Entry storage
  logic [`BP_BTB_DEPTH-1:0] valid_q;
  logic [`BP_ADDR_W-1:0]    tag_q [`BP_BTB_DEPTH];
  logic [`BP_ADDR_W-1:0]    tgt_q [`BP_BTB_DEPTH];

  // Write side
  logic [`BP_BTB_IDX_W-1:0] wr_idx;
  logic [`BP_BTB_DEPTH-1:0] wr_en;

  // Read side
  logic [`BP_BTB_IDX_W-1:0] rd_idx;
  logic                     rd_valid;
  logic [`BP_ADDR_W-1:0]    rd_tag;
  logic [`BP_ADDR_W-1:0]    rd_tgt;
  logic                     tag_eq;

  // One entry written per resolved branch
  assign wr_idx = btb_index(update.pc);

  always_comb begin
    wr_en         = '0;
    wr_en[wr_idx] = update.valid;
  end

  // Valid bits set on write and cleared only by reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_q | wr_en;
    end
  end

  // Tag and target payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
      if (wr_en[i]) begin
        tag_q[i] <= update.pc;
        tgt_q[i] <= update.target;
      end
    end
  end

  // Select the set for the fetch address
  always_comb begin
    rd_idx   = btb_index(lookup_pc);
    rd_valid = valid_q[rd_idx];
    rd_tag   = tag_q[rd_idx];
    rd_tgt   = tgt_q[rd_idx];
  end

  // Whole address kept as the tag
  assign tag_eq = (rd_tag == lookup_pc);

  assign hit = rd_valid && tag_eq;

  // Miss falls through to the fetch address
  assign target = hit ? rd_tgt : lookup_pc;

endmodule

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps
`include "bp_cfg.svh"

// Direction guess and target prediction for the fetch stage
module branch_predictor (
  input  logic                clk,
  input  logic                rst_n,
  input  bp_pkg::bp_lookup_t  lookup,
  input  bp_pkg::bp_update_t  update,
  output bp_pkg::bp_predict_t predict
);
  import bp_pkg::*;

  // Direction from the history predictor
  logic dir_taken;

  // Target side from the BTB
  logic                  btb_hit;
  logic [`BP_ADDR_W-1:0] btb_target;

  // Only the strobe and outcome train the direction side
  two_level_predictor dir_pred_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .upd_valid  (update.valid),
    .upd_taken  (update.taken),
    .pred_taken (dir_taken)
  );

  target_buffer btb_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .update    (update),
    .lookup_pc (lookup.pc),
    .hit       (btb_hit),
    .target    (btb_target)
  );

  // Combined result back to fetch
  assign predict = '{taken: dir_taken, hit: btb_hit, target: btb_target};

endmodule

/* bench/branch_predictor_checker.sv */
`timescale 1ns/1ps
`include "bp_cfg.svh"

// Shadow model of the predictor state, compared against every lookup
module branch_predictor_checker (
  input logic                clk,
  input logic                rst_n,
  input bp_pkg::bp_lookup_t  lookup,
  input bp_pkg::bp_update_t  update,
  input bp_pkg::bp_predict_t predict
);
  import bp_pkg::*;

  // Failure counts per check, summed for the testbench
  int unsigned taken_errs = 0;
  int unsigned hit_errs = 0;
  int unsigned target_errs = 0;
  int unsigned error_count;

  // Model state
  logic [`BP_HIST_W-1:0] hist_m;
  ctr_state_t            ctr_m [`BP_PHT_DEPTH];
  logic                  valid_m [`BP_BTB_DEPTH];
  logic [`BP_ADDR_W-1:0] tag_m [`BP_BTB_DEPTH];
  logic [`BP_ADDR_W-1:0] tgt_m [`BP_BTB_DEPTH];

  logic [`BP_BTB_IDX_W-1:0] upd_idx;
  logic [`BP_BTB_IDX_W-1:0] lk_idx;
  logic                     exp_taken;
  logic                     exp_hit;
  logic [`BP_ADDR_W-1:0]    exp_target;

  assign error_count = taken_errs + hit_errs + target_errs;

  // Address bits [4:2] pick the BTB set
  assign upd_idx = update.pc[`BP_BTB_IDX_LSB +: `BP_BTB_IDX_W];
  assign lk_idx  = lookup.pc[`BP_BTB_IDX_LSB +: `BP_BTB_IDX_W];

  // Both taken states guess taken
  assign exp_taken  = (ctr_m[hist_m] == weak_t) || (ctr_m[hist_m] == strong_t);
  assign exp_hit    = valid_m[lk_idx] && (tag_m[lk_idx] == lookup.pc);
  assign exp_target = exp_hit ? tgt_m[lk_idx] : lookup.pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hist_m <= '0;
      for (int i = 0; i < `BP_PHT_DEPTH; i++) begin
        ctr_m[i] <= strong_nt;
      end
      for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
        valid_m[i] <= 1'b0;
      end
    end else if (update.valid) begin
      hist_m <= {hist_m[`BP_HIST_W-2:0], update.taken};
      // Saturating step on the counter chosen by the old history
      if (update.taken && (ctr_m[hist_m] != strong_t)) begin
        ctr_m[hist_m] <= ctr_state_t'(ctr_m[hist_m] + 2'd1);
      end else if (!update.taken && (ctr_m[hist_m] != strong_nt)) begin
        ctr_m[hist_m] <= ctr_state_t'(ctr_m[hist_m] - 2'd1);
      end
      valid_m[upd_idx] <= 1'b1;
      tag_m[upd_idx]   <= update.pc;
      tgt_m[upd_idx]   <= update.target;
    end
  end

  taken_ok: assert property (@(posedge clk) disable iff (!rst_n)
    predict.taken == exp_taken)
    else begin
      taken_errs++;
      $error("CHECK FAILED %0t: direction guess %0b, model expects %0b",
             $time, $sampled(predict.taken), $sampled(exp_taken));
    end

  hit_ok: assert property (@(posedge clk) disable iff (!rst_n)
    predict.hit == exp_hit)
    else begin
      hit_errs++;
      $error("CHECK FAILED %0t: BTB hit %0b for pc %h, model expects %0b",
             $time, $sampled(predict.hit), $sampled(lookup.pc), $sampled(exp_hit));
    end

  target_ok: assert property (@(posedge clk) disable iff (!rst_n)
    predict.target == exp_target)
    else begin
      target_errs++;
      $error("CHECK FAILED %0t: target %h for pc %h, model expects %h",
             $time, $sampled(predict.target), $sampled(lookup.pc), $sampled(exp_target));
    end

endmodule

/* bench/branch_predictor_tb.sv */
`timescale 1ns/1ps
`include "bp_cfg.svh"

module branch_predictor_tb;
  import bp_pkg::*;

  localparam int CLK_PERIOD = 100;

  // Cycle budget of each phase
  localparam int RESET_CYCLES  = 4;
  localparam int T1_CYCLES     = 20;
  localparam int T2_CYCLES     = 20;
  localparam int T3_CYCLES     = 20;
  localparam int T4_CYCLES     = 30;
  localparam int T5_CYCLES     = 10;
  localparam int MARGIN_CYCLES = 50;
  localparam int RUN_CYCLES    = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                 T4_CYCLES + T5_CYCLES + MARGIN_CYCLES;

  logic        clk = 1'b0;
  logic        rst_n;
  bp_lookup_t  lookup;
  bp_update_t  update;
  bp_predict_t predict;

  int unsigned           tests_run;
  int unsigned           errs_seen;
  logic [`BP_ADDR_W-1:0] fill_pc [`BP_BTB_DEPTH];

  bind branch_predictor branch_predictor_checker chk_inst (.*);

  branch_predictor branch_predictor_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .lookup  (lookup),
    .update  (update),
    .predict (predict)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic bp_update_t make_update(input logic [`BP_ADDR_W-1:0] pc,
                                             input logic taken,
                                             input logic [`BP_ADDR_W-1:0] target);
    bp_update_t u;
    u.valid  = 1'b1;
    u.pc     = pc;
    u.taken  = taken;
    u.target = target;
    return u;
  endfunction

  // Word aligned random address
  function automatic logic [`BP_ADDR_W-1:0] rand_pc();
    return $urandom() & 32'hffff_fffc;
  endfunction

  task automatic drive_cycle(input logic [`BP_ADDR_W-1:0] lk_pc, input bp_update_t upd);
    @(posedge clk);
    lookup.pc <= lk_pc;
    update    <= upd;
  endtask

  // Let the last stimulus reach the checker, then report
  task automatic finish_test(input string name);
    int unsigned errs_now;
    drive_cycle(rand_pc(), '0);
    @(posedge clk);
    #1;
    errs_now = branch_predictor_inst.chk_inst.error_count;
    tests_run++;
    $display("%0t test %0s done, %0d new checker errors", $time, name, errs_now - errs_seen);
    errs_seen = errs_now;
  endtask

  initial begin
    logic [`BP_ADDR_W-1:0] pc_a;
    logic [`BP_ADDR_W-1:0] pc_b;
    logic [`BP_ADDR_W-1:0] pc_c;
    void'($urandom(32'h675b));
    rst_n     = 1'b0;
    lookup    = '0;
    update    = '0;
    tests_run = 0;
    errs_seen = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    repeat (16) drive_cycle(rand_pc(), '0);
    finish_test("reset_state");

    // Saturate taken, then walk the 111 counter down one step at a time
    repeat (8) drive_cycle(rand_pc(), make_update(rand_pc(), 1'b1, rand_pc()));
    drive_cycle(rand_pc(), make_update(rand_pc(), 1'b0, rand_pc()));
    repeat (3) drive_cycle(rand_pc(), make_update(rand_pc(), 1'b1, rand_pc()));
    drive_cycle(rand_pc(), make_update(rand_pc(), 1'b0, rand_pc()));
    repeat (3) drive_cycle(rand_pc(), make_update(rand_pc(), 1'b1, rand_pc()));
    finish_test("saturation");

    for (int i = 0; i < 16; i++) begin
      drive_cycle(rand_pc(), make_update(rand_pc(), i[0], rand_pc()));
    end
    finish_test("history_indexing");

    // One branch per set, so every fill should still be resident
    for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
      fill_pc[i] = (rand_pc() & 32'hffff_ffe3) | (32'(i) << 2);
      drive_cycle(rand_pc(), make_update(fill_pc[i], 1'($urandom()), rand_pc()));
    end
    for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
      drive_cycle(fill_pc[i], '0);
    end
    for (int i = 0; i < `BP_BTB_DEPTH; i++) begin
      drive_cycle(fill_pc[i] ^ 32'h8000_0000, '0);
    end
    finish_test("btb_fill_hit");

    // Three writes to set 5 back to back, each lookup sees the previous entry
    pc_a = (rand_pc() & 32'hffff_ffe3) | (32'd5 << 2);
    pc_b = pc_a ^ 32'h4000_0000;
    pc_c = pc_a ^ 32'h2000_0000;
    drive_cycle(fill_pc[5], make_update(pc_a, 1'($urandom()), rand_pc()));
    drive_cycle(pc_a, make_update(pc_b, 1'($urandom()), rand_pc()));
    drive_cycle(pc_b, make_update(pc_c, 1'($urandom()), rand_pc()));
    drive_cycle(pc_a, '0);
    drive_cycle(pc_b, '0);
    drive_cycle(pc_c, '0);
    finish_test("btb_replacement");

    $display("Tests run: %0d, checker errors: %0d", tests_run, errs_seen);
    if (errs_seen == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("Run timed out after %0d clock cycles", RUN_CYCLES);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+rtl
rtl/bp_pkg.sv
rtl/two_level_predictor.sv
rtl/target_buffer.sv
rtl/branch_predictor.sv
bench/branch_predictor_checker.sv
bench/branch_predictor_tb.sv

/* Makefile */
TOP := branch_predictor_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG) && echo "PASS" || \
		(echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
